// ==== source/uart_pkg.sv ====
package uart_pkg;

	// transmitter phases, one per part of the frame
	typedef enum logic [2:0] {
		TX_IDLE   = 3'd0,
		TX_START  = 3'd1,
		TX_DATA   = 3'd2,
		TX_PARITY = 3'd3,
		TX_STOP   = 3'd4
	} tx_state_t;

	// receiver phases
	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0,    // waiting for a falling edge
		RX_START  = 3'd1,    // half period to start bit middle
		RX_DATA   = 3'd2,
		RX_PARITY = 3'd3,
		RX_STOP   = 3'd4
	} rx_state_t;

	// parity sense of the optional parity bit
	typedef enum logic {
		PARITY_EVEN = 1'b0,  // bit makes total ones even
		PARITY_ODD  = 1'b1
	} parity_mode_t;

	// receiver line synchronizer depth
	localparam int SYNC_STAGES = 3;

endpackage

// ==== source/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx #(
	parameter int DATA_WIDTH = 8,
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1,
	parameter uart_pkg::parity_mode_t PARITY_TYPE = uart_pkg::PARITY_EVEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_enable,
	input  logic [DATA_WIDTH-1:0] i_data,
	output logic                  o_busy,
	output logic                  o_serial_out
);

	localparam int FRAME_BITS = DATA_WIDTH + PARITY_ENABLED + 2;
	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam int BIT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;

	uart_pkg::tx_state_t   state;
	logic [CNT_W-1:0]      clk_cnt;     // cycles spent in the current bit
	logic [BIT_W-1:0]      bit_cnt;     // data bit index
	logic [FRAME_BITS-1:0] frame_sr;    // bit 0 is on the line
	logic [FRAME_BITS-1:0] frame_word;  // frame built from i_data
	logic                  parity_bit;
	logic                  bit_done;
	logic                  start;

	assign start      = i_enable && (state == uart_pkg::TX_IDLE);  // ignored while busy
	assign bit_done   = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));
	assign parity_bit = (^i_data) ^ (PARITY_TYPE == uart_pkg::PARITY_ODD);

	// frame as sent LSB first: start, data, parity, stop
	always_comb begin
		frame_word = '1;                    // stop bit
		frame_word[0] = 1'b0;               // start bit
		frame_word[DATA_WIDTH:1] = i_data;
		if (PARITY_ENABLED != 0) begin
			frame_word[DATA_WIDTH+1] = parity_bit;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= uart_pkg::TX_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			frame_sr <= '1;                 // line idles high
		end else if (start) begin
			state    <= uart_pkg::TX_START;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			frame_sr <= frame_word;         // start bit goes out now
		end else if (state != uart_pkg::TX_IDLE) begin
			if (bit_done) begin
				clk_cnt  <= '0;
				frame_sr <= {1'b1, frame_sr[FRAME_BITS-1:1]};  // refill with idle level
				case (state)
					uart_pkg::TX_START: begin
						state <= uart_pkg::TX_DATA;
					end
					uart_pkg::TX_DATA: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(DATA_WIDTH - 1)) begin
							if (PARITY_ENABLED != 0) begin
								state <= uart_pkg::TX_PARITY;
							end else begin
								state <= uart_pkg::TX_STOP;
							end
						end
					end
					uart_pkg::TX_PARITY: begin
						state <= uart_pkg::TX_STOP;
					end
					default: begin
						state <= uart_pkg::TX_IDLE;  // stop bit held a full period
					end
				endcase
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	assign o_busy       = (state != uart_pkg::TX_IDLE);
	assign o_serial_out = frame_sr[0];

	// busy is high for the whole frame, so a fall means it rose one frame earlier
	a_busy_full_frame: assert property (@(posedge clk) disable iff (reset)
		$fell(o_busy) |-> $past(o_busy, FRAME_CYCLES) && !$past(o_busy, FRAME_CYCLES + 1));

	a_idle_line_high: assert property (@(posedge clk) disable iff (reset)
		!o_busy |-> o_serial_out);

endmodule

// ==== source/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx #(
	parameter int DATA_WIDTH = 8,
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1,
	parameter uart_pkg::parity_mode_t PARITY_TYPE = uart_pkg::PARITY_EVEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_serial_in,
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_valid,
	output logic                  o_rx_error
);

	localparam int CNT_W = $clog2(CLOCKS_PER_BIT);
	localparam int BIT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
	localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

	logic [uart_pkg::SYNC_STAGES-1:0] sync_sr;  // line synchronizer
	logic                             line;     // synchronized line
	logic                             line_prev;
	logic                             fall;
	uart_pkg::rx_state_t              state;
	logic [CNT_W-1:0]                 clk_cnt;
	logic [BIT_W-1:0]                 bit_cnt;
	logic [DATA_WIDTH-1:0]            data_sr;     // LSB arrives first
	logic                             parity_acc;  // xor of data and parity bits
	logic                             half_done;
	logic                             bit_done;
	logic                             parity_bad;

	assign line      = sync_sr[uart_pkg::SYNC_STAGES-1];
	assign fall      = line_prev && !line;
	assign half_done = (clk_cnt == CNT_W'(HALF_BIT - 1));
	assign bit_done  = (clk_cnt == CNT_W'(CLOCKS_PER_BIT - 1));
	assign parity_bad = (PARITY_ENABLED != 0) &&
		(parity_acc != (PARITY_TYPE == uart_pkg::PARITY_ODD));

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_sr   <= '1;
			line_prev <= 1'b1;
		end else begin
			sync_sr   <= {sync_sr[uart_pkg::SYNC_STAGES-2:0], i_serial_in};
			line_prev <= line;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= uart_pkg::RX_IDLE;
			clk_cnt    <= '0;
			bit_cnt    <= '0;
			o_rx_valid <= 1'b0;
			o_rx_error <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;  // pulses only
			o_rx_error <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE: begin
					if (fall) begin
						state   <= uart_pkg::RX_START;
						clk_cnt <= '0;
					end
				end
				uart_pkg::RX_START: begin
					if (half_done) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						if (line) begin
							state <= uart_pkg::RX_IDLE;  // glitch, not a start bit
						end else begin
							state <= uart_pkg::RX_DATA;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_DATA: begin
					if (bit_done) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_W'(DATA_WIDTH - 1)) begin
							if (PARITY_ENABLED != 0) begin
								state <= uart_pkg::RX_PARITY;
							end else begin
								state <= uart_pkg::RX_STOP;
							end
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_PARITY: begin
					if (bit_done) begin
						clk_cnt <= '0;
						state   <= uart_pkg::RX_STOP;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				uart_pkg::RX_STOP: begin
					if (bit_done) begin
						clk_cnt    <= '0;
						state      <= uart_pkg::RX_IDLE;
						o_rx_valid <= 1'b1;
						o_rx_error <= parity_bad || !line;  // stop bit must be 1
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					state <= uart_pkg::RX_IDLE;
				end
			endcase
		end
	end

	// sampled bits, captured at mid-bit
	always_ff @(posedge clk) begin
		if ((state == uart_pkg::RX_START) && half_done) begin
			parity_acc <= 1'b0;
		end else if (((state == uart_pkg::RX_DATA) || (state == uart_pkg::RX_PARITY)) && bit_done) begin
			parity_acc <= parity_acc ^ line;
		end
		if ((state == uart_pkg::RX_DATA) && bit_done) begin
			data_sr <= DATA_WIDTH'({line, data_sr} >> 1);
		end
		if ((state == uart_pkg::RX_STOP) && bit_done) begin
			o_rx_data <= data_sr;  // held until next frame
		end
	end

	a_error_with_valid: assert property (@(posedge clk) disable iff (reset)
		o_rx_error |-> o_rx_valid);

	a_valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
		o_rx_valid |=> !o_rx_valid);

	a_state_legal: assert property (@(posedge clk) disable iff (reset)
		state inside {uart_pkg::RX_IDLE, uart_pkg::RX_START, uart_pkg::RX_DATA,
			uart_pkg::RX_PARITY, uart_pkg::RX_STOP});

endmodule

// ==== source/uart_link.sv ====
`timescale 1ns/100ps

module uart_link #(
	parameter int DATA_WIDTH = 8,
	parameter int CLOCKS_PER_BIT = 8,      // at least 4
	parameter int PARITY_ENABLED = 1,
	parameter uart_pkg::parity_mode_t PARITY_TYPE = uart_pkg::PARITY_EVEN
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  i_enable,
	input  logic [DATA_WIDTH-1:0] i_data,
	output logic                  o_busy,
	output logic                  o_serial_out,
	input  logic                  i_serial_in,  // looped back outside
	output logic [DATA_WIDTH-1:0] o_rx_data,
	output logic                  o_rx_valid,
	output logic                  o_rx_error
);

	uart_tx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_TYPE    (PARITY_TYPE)
	) u_tx (
		.clk          (clk),
		.reset        (reset),
		.i_enable     (i_enable),
		.i_data       (i_data),
		.o_busy       (o_busy),
		.o_serial_out (o_serial_out)
	);

	uart_rx #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_TYPE    (PARITY_TYPE)
	) u_rx (
		.clk         (clk),
		.reset       (reset),
		.i_serial_in (i_serial_in),
		.o_rx_data   (o_rx_data),
		.o_rx_valid  (o_rx_valid),
		.o_rx_error  (o_rx_error)
	);

endmodule

// ==== dv/uart_checker.sv ====
`timescale 1ns/100ps

module uart_checker #(
	parameter int DATA_WIDTH = 8,
	parameter int CLOCKS_PER_BIT = 8,
	parameter int PARITY_ENABLED = 1
) (
	input logic                  clk,
	input logic                  reset,
	input logic                  i_enable,
	input logic [DATA_WIDTH-1:0] i_data,
	input logic                  i_busy,
	input logic                  i_serial_out,
	input logic [DATA_WIDTH-1:0] i_rx_data,
	input logic                  i_rx_valid,
	input logic                  i_rx_error,
	input int                    i_fault_bit,  // frame bit inverted on the line, -1 if none
	input uart_pkg::rx_state_t   i_rx_state
);

	localparam int FRAME_BITS = DATA_WIDTH + PARITY_ENABLED + 2;
	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
	localparam int MAX_LATENCY = uart_pkg::SYNC_STAGES + FRAME_CYCLES - CLOCKS_PER_BIT / 2 + 2;

	logic [DATA_WIDTH-1:0] exp_data_q[$];
	logic                  exp_err_q[$];
	int                    start_cycle_q[$];  // cycle the enable was taken
	int cycle_cnt = 0;
	int busy_cycles = 0;
	int error_count = 0;
	int test_errors = 0;   // error count at the last test boundary
	int test_count = 0;
	int taken_count = 0;
	int valid_count = 0;

	// data bit k travels as frame bit k+1
	function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [DATA_WIDTH-1:0] data,
		input int fault);
		if (fault >= 1 && fault <= DATA_WIDTH) begin
			return data ^ (DATA_WIDTH'(1) << (fault - 1));
		end
		return data;
	endfunction

	function automatic logic expected_error(input int fault);
		if (fault >= 1 && fault <= DATA_WIDTH) begin
			return PARITY_ENABLED != 0;  // one flipped data bit breaks parity
		end
		if (PARITY_ENABLED != 0 && fault == DATA_WIDTH + 1) begin
			return 1'b1;
		end
		return fault == FRAME_BITS - 1;  // stop bit forced low
	endfunction

	always @(posedge clk) begin
		logic [DATA_WIDTH-1:0] head_data;
		logic                  head_err;
		int                    latency;
		if (reset) begin
			busy_cycles = 0;
		end else begin
			cycle_cnt = cycle_cnt + 1;
			if (i_enable && !i_busy) begin  // enable taken this edge
				exp_data_q.push_back(expected_word(i_data, i_fault_bit));
				exp_err_q.push_back(expected_error(i_fault_bit));
				start_cycle_q.push_back(cycle_cnt);
				taken_count++;
			end
			if (i_busy) begin
				busy_cycles++;
			end else begin
				if (busy_cycles != 0 && busy_cycles != FRAME_CYCLES) begin
					$display("CHECK FAILED at %0t: o_busy high cycles expected %0d got %0d",
						$time, FRAME_CYCLES, busy_cycles);
					error_count++;
				end
				busy_cycles = 0;
				if (!i_serial_out) begin
					$display("CHECK FAILED at %0t: o_serial_out expected 1 got 0 (o_busy low)",
						$time);
					error_count++;
				end
			end
			if (i_rx_valid) begin
				valid_count++;
				if (exp_data_q.size() == 0) begin
					$display("%0t: o_rx_valid pulsed with no frame outstanding (rx state %s)",
						$time, i_rx_state.name());
					error_count++;
				end else begin
					head_data = exp_data_q.pop_front();
					head_err = exp_err_q.pop_front();
					latency = cycle_cnt - start_cycle_q.pop_front() - 1;
					if (i_rx_data !== head_data) begin
						$display("CHECK FAILED at %0t: o_rx_data expected %h got %h",
							$time, head_data, i_rx_data);
						error_count++;
					end
					if (i_rx_error !== head_err) begin
						$display("CHECK FAILED at %0t: o_rx_error expected %b got %b",
							$time, head_err, i_rx_error);
						error_count++;
					end
					if (latency > MAX_LATENCY) begin
						$display("CHECK FAILED at %0t: rx latency expected <= %0d got %0d",
							$time, MAX_LATENCY, latency);
						error_count++;
					end
				end
			end
		end
	end

	function automatic int pending_count();
		return exp_data_q.size();
	endfunction

	task automatic compare_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("%s: done, %0d errors", name, error_count - test_errors);
		test_errors = error_count;
	endtask

	task automatic print_summary();
		$display("summary: %0d tests, %0d frames taken, %0d received, %0d errors",
			test_count, taken_count, valid_count, error_count);
	endtask

endmodule

// ==== dv/tb_uart_link.sv ====
`timescale 1ns/100ps

module tb_uart_link;

	localparam int DATA_WIDTH = 8;
	localparam int CLOCKS_PER_BIT = 8;
	localparam int PARITY_ENABLED = 1;
	localparam uart_pkg::parity_mode_t PARITY_TYPE = uart_pkg::PARITY_EVEN;
	localparam int FRAME_BITS = DATA_WIDTH + PARITY_ENABLED + 2;
	localparam int FRAME_CYCLES = FRAME_BITS * CLOCKS_PER_BIT;
	localparam int WAIT_LIMIT = 4 * FRAME_CYCLES;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  enable;
	logic [DATA_WIDTH-1:0] data;
	logic                  busy;
	logic                  serial_out;
	logic                  serial_in;
	logic [DATA_WIDTH-1:0] rx_data;
	logic                  rx_valid;
	logic                  rx_error;
	logic                  inject;
	logic                  timed_out;
	int                    fault_bit;                    // armed for the next frame
	int                    active_fault = -1;
	int                    frame_cycle = FRAME_CYCLES;  // FRAME_CYCLES means no frame
	integer                seed;

	always #2 clk = ~clk;

	uart_link #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_ENABLED (PARITY_ENABLED),
		.PARITY_TYPE    (PARITY_TYPE)
	) dut (
		.clk          (clk),
		.reset        (reset),
		.i_enable     (enable),
		.i_data       (data),
		.o_busy       (busy),
		.o_serial_out (serial_out),
		.i_serial_in  (serial_in),
		.o_rx_data    (rx_data),
		.o_rx_valid   (rx_valid),
		.o_rx_error   (rx_error)
	);

	uart_checker #(
		.DATA_WIDTH     (DATA_WIDTH),
		.CLOCKS_PER_BIT (CLOCKS_PER_BIT),
		.PARITY_ENABLED (PARITY_ENABLED)
	) chk (
		.clk          (clk),
		.reset        (reset),
		.i_enable     (enable),
		.i_data       (data),
		.i_busy       (busy),
		.i_serial_out (serial_out),
		.i_rx_data    (rx_data),
		.i_rx_valid   (rx_valid),
		.i_rx_error   (rx_error),
		.i_fault_bit  (fault_bit),
		.i_rx_state   (dut.u_rx.state)
	);

	// position inside the current frame, for the fault window
	always @(posedge clk) begin
		if (reset) begin
			frame_cycle  <= FRAME_CYCLES;
			active_fault <= -1;
		end else if (enable && !busy) begin
			frame_cycle  <= 0;
			active_fault <= fault_bit;
		end else if (frame_cycle < FRAME_CYCLES) begin
			frame_cycle <= frame_cycle + 1;
		end
	end

	assign inject    = (frame_cycle < FRAME_CYCLES) &&
		(frame_cycle / CLOCKS_PER_BIT == active_fault);
	assign serial_in = serial_out ^ inject;  // loopback

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#0.5;
		end
	endtask

	task automatic wait_idle(input string what);
		int count;
		count = 0;
		while (busy && !timed_out) begin
			@(posedge clk);
			#0.5;
			count++;
			if (count > WAIT_LIMIT) begin
				$display("timeout: %s, o_busy never fell", what);
				timed_out = 1'b1;
			end
		end
	endtask

	// tx idle and every taken frame received
	task automatic wait_drain(input string what);
		int count;
		count = 0;
		while (!timed_out && (busy || chk.pending_count() != 0)) begin
			@(posedge clk);
			#0.5;
			count++;
			if (count > WAIT_LIMIT) begin
				$display("timeout: %s, frames still outstanding", what);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic send_word(input logic [DATA_WIDTH-1:0] word, input int fault);
		wait_idle("transmitter idle before send");
		if (!timed_out) begin
			enable    = 1'b1;
			data      = word;
			fault_bit = fault;
			@(posedge clk);
			#0.5;
			enable    = 1'b0;
			fault_bit = -1;
		end
	endtask

	task automatic round_trip();
		repeat (40) begin
			send_word(DATA_WIDTH'($random(seed)), -1);
			wait_drain("round trip frame");
		end
		chk.end_test("round trip");
	endtask

	task automatic frame_length();
		repeat (6) begin
			send_word(DATA_WIDTH'($random(seed)), -1);
			wait_idle("end of frame");
			idle_cycles($unsigned($random(seed)) % 16);  // random gap
		end
		wait_drain("frame length frames");
		chk.end_test("frame length");
	endtask

	task automatic back_to_back();
		repeat (10) begin
			send_word(DATA_WIDTH'($random(seed)), -1);
		end
		wait_drain("back to back frames");
		chk.end_test("back to back");
	endtask

	task automatic busy_enables();
		int start_valid;
		int count;
		start_valid = chk.valid_count;
		repeat (8) begin
			send_word(DATA_WIDTH'($random(seed)), -1);
			count = 0;
			while (busy && !timed_out) begin  // stray enables, all while busy
				enable = 1'($random(seed));
				data   = DATA_WIDTH'($random(seed));
				@(posedge clk);
				#0.5;
				enable = 1'b0;
				count++;
				if (count > WAIT_LIMIT) begin
					$display("timeout: stray enables, o_busy never fell");
					timed_out = 1'b1;
				end
			end
		end
		wait_drain("frames with stray enables");
		chk.compare_count("o_rx_valid pulses", 8, chk.valid_count - start_valid);
		chk.end_test("enables while busy");
	endtask

	task automatic parity_fault();
		send_word(DATA_WIDTH'($random(seed)), 1 + $unsigned($random(seed)) % DATA_WIDTH);
		wait_drain("data bit fault frame");
		send_word(DATA_WIDTH'($random(seed)), -1);
		wait_drain("clean frame after data fault");
		send_word(DATA_WIDTH'($random(seed)), DATA_WIDTH + 1);  // parity bit
		wait_drain("parity bit fault frame");
		send_word(DATA_WIDTH'($random(seed)), -1);
		wait_drain("clean frame after parity fault");
		chk.end_test("parity fault");
	endtask

	task automatic framing_fault();
		repeat (2) begin
			send_word(DATA_WIDTH'($random(seed)), FRAME_BITS - 1);
			wait_drain("stop bit fault frame");
			idle_cycles(CLOCKS_PER_BIT);  // line high one bit period
			send_word(DATA_WIDTH'($random(seed)), -1);
			wait_drain("clean frame after stop fault");
		end
		chk.end_test("framing fault");
	endtask

	initial begin
		seed      = 32'hf7a06440;
		reset     = 1'b1;
		enable    = 1'b0;
		data      = '0;
		fault_bit = -1;
		timed_out = 1'b0;
		repeat (5) @(posedge clk);
		#0.5;
		reset = 1'b0;
		idle_cycles(CLOCKS_PER_BIT);
		if (!timed_out) round_trip();
		if (!timed_out) frame_length();
		if (!timed_out) back_to_back();
		if (!timed_out) busy_enables();
		if (!timed_out) parity_fault();
		if (!timed_out) framing_fault();
		chk.print_summary();
		if (timed_out || chk.error_count != 0) begin
			$display("Test failed");
		end else begin
			$display("Test passed");
		end
		$finish;
	end

endmodule

// ==== uart_link.f ====
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_link.sv
dv/uart_checker.sv
dv/tb_uart_link.sv

// ==== Makefile ====
# Verilator simulation of the UART link testbench
# override on the command line, e.g. make sim LOG=run.log

TOP       ?= tb_uart_link
FILELIST  ?= uart_link.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed, log in $(LOG)"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
